// ==== logic/rn_config.svh ====
`ifndef RN_CONFIG_SVH
`define RN_CONFIG_SVH

// Architectural register index width
// 32 integer registers, r0 hardwired to zero
`define RN_ARF_AW 5

// Physical register index width
// 64 physical registers, p0 stays the zero register
`define RN_PRF_AW 6

// Lanes per rename bundle
// Free list selection is unrolled for two lanes
`define RN_ISSUE_W 2

// Dispatch queue depth in bundles
// Also the credit counter reset value
`define RN_CREDITS 4

// Instruction word width
`define RN_XLEN 32

`endif

// ==== logic/isa_pkg.sv ====
package isa_pkg;

   // Major opcode field width
   localparam int OPC_W = 7;

   // Register-register layout
   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [OPC_W-1:0] opcode;
   } r_form_t;

   // Register-immediate layout
   // rs1, rd and opcode sit where the register form has them
   typedef struct packed {
      logic [11:0] imm12;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [OPC_W-1:0] opcode;
   } i_form_t;

   // One instruction word, two views
   typedef union packed {
      r_form_t r_form;
      i_form_t i_form;
   } insn_u;

   // ALU op, reads rs1 and rs2, writes rd
   localparam logic [OPC_W-1:0] OP_REG = 7'b0110011;
   // ALU op with immediate, reads rs1, writes rd
   localparam logic [OPC_W-1:0] OP_IMM = 7'b0010011;
   // Store, reads base and data, no destination
   localparam logic [OPC_W-1:0] OP_STORE = 7'b0100011;
   // Conditional branch, compares two sources
   localparam logic [OPC_W-1:0] OP_BRANCH = 7'b1100011;

   // anything else carries no register operands

endpackage

// ==== logic/rn_pkg.sv ====
package rn_pkg;

`include "rn_config.svh"

   // Register fields of one lane after decode
   typedef struct packed {
      logic valid;
      logic rs1_used;
      logic rs2_used;
      // Set only for a real destination, never r0
      logic rd_we;
      logic [`RN_ARF_AW-1:0] rs1;
      logic [`RN_ARF_AW-1:0] rs2;
      logic [`RN_ARF_AW-1:0] rd;
   } dec_t;

   // Renamed micro-op handed to the dispatch queue
   typedef struct packed {
      logic valid;
      isa_pkg::insn_u insn;
      logic [`RN_PRF_AW-1:0] prs1;
      logic [`RN_PRF_AW-1:0] prs2;
      // New destination, p0 when the lane writes nothing
      logic [`RN_PRF_AW-1:0] prd;
      // Mapping replaced by prd, released at commit
      logic [`RN_PRF_AW-1:0] pfree;
      logic [`RN_ARF_AW-1:0] rd;
      logic rd_we;
   } uop_t;

   // One retiring instruction, in program order
   typedef struct packed {
      logic valid;
      logic rd_we;
      logic [`RN_ARF_AW-1:0] rd;
      logic [`RN_PRF_AW-1:0] prd;
      logic [`RN_PRF_AW-1:0] pfree;
   } cmt_t;

endpackage

// ==== logic/rn_decode.sv ====
`timescale 1ns/1ps

`include "rn_config.svh"

module rn_decode
(
   input  logic                                clk,
   input  logic                                rst_n,
   input  isa_pkg::insn_u [`RN_ISSUE_W-1:0]    in_insn,
   input  logic                                in_valid,
   output rn_pkg::dec_t [`RN_ISSUE_W-1:0]      dec
);

   // Opcode is one of the four register formats
   logic [`RN_ISSUE_W-1:0] known;

   always_comb
   begin
      for (int k = 0; k < `RN_ISSUE_W; k++)
      begin
         // Unused fields stay zero so lookups land on r0
         dec[k] = '0;
         dec[k].valid = in_valid;
         case (in_insn[k].r_form.opcode)
            isa_pkg::OP_REG:
            begin
               dec[k].rs1_used = 1'b1;
               dec[k].rs2_used = 1'b1;
               dec[k].rs1 = in_insn[k].r_form.rs1;
               dec[k].rs2 = in_insn[k].r_form.rs2;
               dec[k].rd = in_insn[k].r_form.rd;
               // r0 writes are dropped, no allocation
               dec[k].rd_we = (in_insn[k].r_form.rd != '0);
            end
            isa_pkg::OP_IMM:
            begin
               // Immediate view, no second source
               dec[k].rs1_used = 1'b1;
               dec[k].rs1 = in_insn[k].i_form.rs1;
               dec[k].rd = in_insn[k].i_form.rd;
               dec[k].rd_we = (in_insn[k].i_form.rd != '0);
            end
            isa_pkg::OP_STORE,
            isa_pkg::OP_BRANCH:
            begin
               dec[k].rs1_used = 1'b1;
               dec[k].rs2_used = 1'b1;
               dec[k].rs1 = in_insn[k].r_form.rs1;
               dec[k].rs2 = in_insn[k].r_form.rs2;
            end
            default:
            begin
            end
         endcase
      end
   end

   // Unknown opcode must reach rename with no operands
   for (genvar g = 0; g < `RN_ISSUE_W; g++)
   begin : g_chk
      // Known formats straight from the raw opcode
      assign known[g] = (in_insn[g].r_form.opcode == isa_pkg::OP_REG) ||
                        (in_insn[g].r_form.opcode == isa_pkg::OP_IMM) ||
                        (in_insn[g].r_form.opcode == isa_pkg::OP_STORE) ||
                        (in_insn[g].r_form.opcode == isa_pkg::OP_BRANCH);

      a_unknown_no_regs: assert property (@(posedge clk) disable iff (!rst_n)
         (in_valid && !known[g]) |->
            !(dec[g].rs1_used || dec[g].rs2_used || dec[g].rd_we));
   end

endmodule

// ==== logic/rn_rat.sv ====
`timescale 1ns/1ps

`include "rn_config.svh"

module rn_rat
(
   input  logic                                          clk,
   input  logic                                          rst_n,
   input  rn_pkg::dec_t [`RN_ISSUE_W-1:0]                dec,
   input  logic                                          fire,
   input  logic [`RN_ISSUE_W-1:0][`RN_PRF_AW-1:0]        alloc_prd,
   input  logic                                          rollback,
   input  rn_pkg::cmt_t                                  cmt,
   output logic [`RN_ISSUE_W-1:0][`RN_PRF_AW-1:0]        prs1,
   output logic [`RN_ISSUE_W-1:0][`RN_PRF_AW-1:0]        prs2,
   output logic [`RN_ISSUE_W-1:0][`RN_PRF_AW-1:0]        pfree
);

   localparam int N_ARF = 1 << `RN_ARF_AW;

   // Speculative map, read by rename
   logic [`RN_PRF_AW-1:0] rat_q [N_ARF];
   // Architectural map, written by commit only
   logic [`RN_PRF_AW-1:0] arat_q [N_ARF];
   logic [`RN_PRF_AW-1:0] arat_nxt [N_ARF];

   // Lookups, lane 1 sees lane 0's fresh destination
   always_comb
   begin
      prs1[0] = rat_q[dec[0].rs1];
      prs2[0] = rat_q[dec[0].rs2];
      pfree[0] = rat_q[dec[0].rd];
      prs1[1] = (dec[0].rd_we && (dec[0].rd == dec[1].rs1)) ? alloc_prd[0]
                                                              : rat_q[dec[1].rs1];
      prs2[1] = (dec[0].rd_we && (dec[0].rd == dec[1].rs2)) ? alloc_prd[0]
                                                              : rat_q[dec[1].rs2];
      // Same rd twice, lane 1 replaces lane 0's register
      pfree[1] = (dec[0].rd_we && (dec[0].rd == dec[1].rd)) ? alloc_prd[0]
                                                             : rat_q[dec[1].rd];
   end

   always_comb
   begin
      arat_nxt = arat_q;
      if (cmt.valid && cmt.rd_we)
         arat_nxt[cmt.rd] = cmt.prd;
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         // Identity map out of reset
         for (int k = 0; k < N_ARF; k++)
         begin
            rat_q[k] <= `RN_PRF_AW'(k);
            arat_q[k] <= `RN_PRF_AW'(k);
         end
      end
      else
      begin
         arat_q <= arat_nxt;
         // Rollback also picks up a commit in the same cycle
         if (rollback)
            rat_q <= arat_nxt;
         else if (fire)
         begin
            // later lane wins on equal rd
            for (int k = 0; k < `RN_ISSUE_W; k++)
               if (dec[k].rd_we)
                  rat_q[dec[k].rd] <= alloc_prd[k];
         end
      end
   end

   // Retiring r0 would corrupt the zero mapping
   a_no_r0_commit: assert property (@(posedge clk) disable iff (!rst_n)
      (cmt.valid && cmt.rd_we) |-> (cmt.rd != '0));

endmodule

// ==== logic/rn_fl.sv ====
`timescale 1ns/1ps

`include "rn_config.svh"

module rn_fl
(
   input  logic                                          clk,
   input  logic                                          rst_n,
   input  rn_pkg::dec_t [`RN_ISSUE_W-1:0]                dec,
   input  logic                                          fire,
   input  logic                                          rollback,
   input  rn_pkg::cmt_t                                  cmt,
   output logic [`RN_ISSUE_W-1:0][`RN_PRF_AW-1:0]        alloc_prd,
   output logic                                          fl_stall
);

   localparam int N_PRF = 1 << `RN_PRF_AW;
   localparam int N_ARF = 1 << `RN_ARF_AW;
   // Registers above the identity map start out free
   localparam logic [N_PRF-1:0] FL_RST = {{(N_PRF-N_ARF){1'b1}}, {N_ARF{1'b0}}};

   // Bit 0 is never stored, p0 always busy
   logic [N_PRF-1:1] fl_q;
   logic [N_PRF-1:1] afl_q;
   logic [N_PRF-1:0] fl_0;
   logic [N_PRF-1:0] fl_1;
   logic [N_PRF-1:0] afl_full;
   logic [N_PRF-1:0] fl_nxt;
   logic [N_PRF-1:0] afl_nxt;
   logic gs_0;
   logic gs_1;
   logic cmt_we;

   // Lowest set bit wins
   function automatic logic [`RN_PRF_AW-1:0] lowest_free(input logic [N_PRF-1:0] vec);
      logic [`RN_PRF_AW-1:0] idx;
      idx = '0;
      for (int k = N_PRF-1; k >= 0; k--)
         if (vec[k])
            idx = `RN_PRF_AW'(k);
      return idx;
   endfunction

   assign fl_0 = {fl_q, 1'b0};
   assign afl_full = {afl_q, 1'b0};
   assign cmt_we = cmt.valid && cmt.rd_we;

   // Lane 0 takes the lowest free register
   assign alloc_prd[0] = lowest_free(fl_0);
   assign gs_0 = |fl_0;
   // Lane 1 skips lane 0's pick even if lane 0 does not write
   assign fl_1 = fl_0 & ~(N_PRF'(1) << alloc_prd[0]);
   assign alloc_prd[1] = lowest_free(fl_1);
   assign gs_1 = |fl_1;

   // Hold the whole bundle back if any writer comes up empty
   assign fl_stall = (dec[0].valid && dec[0].rd_we && !gs_0) ||
                     (dec[1].valid && dec[1].rd_we && !gs_1);

   always_comb
   begin
      fl_nxt = fl_0;
      if (fire)
      begin
         for (int k = 0; k < `RN_ISSUE_W; k++)
            if (dec[k].rd_we)
               fl_nxt[alloc_prd[k]] = 1'b0;
      end
      if (cmt_we)
         fl_nxt[cmt.pfree] = 1'b1;
      // Commit moves ownership from pfree to prd
      afl_nxt = afl_full;
      if (cmt_we)
      begin
         afl_nxt[cmt.prd] = 1'b0;
         afl_nxt[cmt.pfree] = 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         fl_q <= FL_RST[N_PRF-1:1];
         afl_q <= FL_RST[N_PRF-1:1];
      end
      else
      begin
         fl_q <= rollback ? afl_nxt[N_PRF-1:1] : fl_nxt[N_PRF-1:1];
         afl_q <= afl_nxt[N_PRF-1:1];
      end
   end

   // Double free means rename and commit disagree
   a_pfree_busy: assert property (@(posedge clk) disable iff (!rst_n)
      cmt_we |-> !afl_full[cmt.pfree]);

endmodule

// ==== logic/rn_dispatch.sv ====
`timescale 1ns/1ps

`include "rn_config.svh"

module rn_dispatch
(
   input  logic                                          clk,
   input  logic                                          rst_n,
   input  logic                                          in_valid,
   input  logic                                          fl_stall,
   input  logic                                          rollback,
   input  logic                                          credit_ret,
   input  rn_pkg::dec_t [`RN_ISSUE_W-1:0]                dec,
   input  isa_pkg::insn_u [`RN_ISSUE_W-1:0]              in_insn,
   input  logic [`RN_ISSUE_W-1:0][`RN_PRF_AW-1:0]        prs1,
   input  logic [`RN_ISSUE_W-1:0][`RN_PRF_AW-1:0]        prs2,
   input  logic [`RN_ISSUE_W-1:0][`RN_PRF_AW-1:0]        alloc_prd,
   input  logic [`RN_ISSUE_W-1:0][`RN_PRF_AW-1:0]        pfree,
   output logic                                          fire,
   output logic                                          in_ready,
   output logic                                          out_valid,
   output rn_pkg::uop_t [`RN_ISSUE_W-1:0]                out_uop
);

   localparam int CW = $clog2(`RN_CREDITS + 1);

   // Free dispatch queue slots, one per bundle
   logic [CW-1:0] credit_q;
   rn_pkg::uop_t [`RN_ISSUE_W-1:0] uop_nxt;

   // Credit is spent at acceptance, so ready drops right away
   assign in_ready = (credit_q != '0) && !fl_stall && !rollback;
   assign fire = in_valid && in_ready;

   always_comb
   begin
      for (int k = 0; k < `RN_ISSUE_W; k++)
      begin
         uop_nxt[k].valid = dec[k].valid;
         uop_nxt[k].insn = in_insn[k];
         uop_nxt[k].prs1 = prs1[k];
         uop_nxt[k].prs2 = prs2[k];
         // Non-writing lane reports p0 for both
         uop_nxt[k].prd = dec[k].rd_we ? alloc_prd[k] : '0;
         uop_nxt[k].pfree = dec[k].rd_we ? pfree[k] : '0;
         uop_nxt[k].rd = dec[k].rd;
         uop_nxt[k].rd_we = dec[k].rd_we;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         out_valid <= 1'b0;
         credit_q <= CW'(`RN_CREDITS);
      end
      else
      begin
         out_valid <= fire;
         // Queue is flushed on rollback, all slots come back
         if (rollback)
            credit_q <= CW'(`RN_CREDITS);
         else
            credit_q <= credit_q - CW'(fire) + CW'(credit_ret);
      end
   end

   // Payload only moves on acceptance
   always_ff @(posedge clk)
   begin
      if (fire)
         out_uop <= uop_nxt;
   end

   // Queue must never hand back more than it holds
   a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
      credit_q <= CW'(`RN_CREDITS));

endmodule

// ==== logic/rn_top.sv ====
`timescale 1ns/1ps

`include "rn_config.svh"

module rn_top
(
   input  logic                                  clk,
   input  logic                                  rst_n,
   input  logic                                  in_valid,
   input  isa_pkg::insn_u [`RN_ISSUE_W-1:0]      in_insn,
   output logic                                  in_ready,
   output logic                                  out_valid,
   output rn_pkg::uop_t [`RN_ISSUE_W-1:0]        out_uop,
   input  logic                                  credit_ret,
   input  rn_pkg::cmt_t                          cmt,
   input  logic                                  rollback
);

   rn_pkg::dec_t [`RN_ISSUE_W-1:0] dec;
   logic [`RN_ISSUE_W-1:0][`RN_PRF_AW-1:0] prs1;
   logic [`RN_ISSUE_W-1:0][`RN_PRF_AW-1:0] prs2;
   logic [`RN_ISSUE_W-1:0][`RN_PRF_AW-1:0] pfree;
   logic [`RN_ISSUE_W-1:0][`RN_PRF_AW-1:0] alloc_prd;
   // Bundle accepted this cycle
   logic fire;
   logic fl_stall;

   // Register fields per lane
   rn_decode u_decode (.clk(clk), .rst_n(rst_n), .in_insn(in_insn),
                       .in_valid(in_valid), .dec(dec));

   // Source mapping and replaced destinations
   rn_rat u_rat (.clk(clk), .rst_n(rst_n), .dec(dec), .fire(fire),
                 .alloc_prd(alloc_prd), .rollback(rollback), .cmt(cmt),
                 .prs1(prs1), .prs2(prs2), .pfree(pfree));

   // New destinations
   rn_fl u_fl (.clk(clk), .rst_n(rst_n), .dec(dec), .fire(fire),
               .rollback(rollback), .cmt(cmt), .alloc_prd(alloc_prd),
               .fl_stall(fl_stall));

   // Acceptance, credits and the output register
   rn_dispatch u_dispatch (.clk(clk), .rst_n(rst_n), .in_valid(in_valid),
                           .fl_stall(fl_stall), .rollback(rollback),
                           .credit_ret(credit_ret), .dec(dec), .in_insn(in_insn),
                           .prs1(prs1), .prs2(prs2), .alloc_prd(alloc_prd),
                           .pfree(pfree), .fire(fire), .in_ready(in_ready),
                           .out_valid(out_valid), .out_uop(out_uop));

endmodule

// ==== testbench/tb_rn_model.svh ====
`ifndef TB_RN_MODEL_SVH
`define TB_RN_MODEL_SVH

localparam int M_ARF = 1 << `RN_ARF_AW;
localparam int M_PRF = 1 << `RN_PRF_AW;

// One renamed bundle, lane 0 in the low slot
typedef rn_pkg::uop_t [`RN_ISSUE_W-1:0] bundle_t;

// Speculative and architectural state of the model
logic [`RN_PRF_AW-1:0] m_rat [M_ARF];
logic [`RN_PRF_AW-1:0] m_arat [M_ARF];
// Set bit means free, p0 never free
logic [M_PRF-1:0] m_fl;
logic [M_PRF-1:0] m_afl;

function automatic void model_reset();
   for (int k = 0; k < M_ARF; k++)
   begin
      m_rat[k] = `RN_PRF_AW'(k);
      m_arat[k] = `RN_PRF_AW'(k);
   end
   m_fl = '0;
   // Everything above the identity map
   for (int k = M_ARF; k < M_PRF; k++)
      m_fl[k] = 1'b1;
   m_afl = m_fl;
endfunction

// Register use by opcode class
function automatic rn_pkg::dec_t lane_use(input isa_pkg::insn_u w);
   rn_pkg::dec_t d;
   logic [6:0] op;
   d = '0;
   d.valid = 1'b1;
   op = w.r_form.opcode;
   if (op == isa_pkg::OP_REG || op == isa_pkg::OP_STORE || op == isa_pkg::OP_BRANCH)
   begin
      d.rs1_used = 1'b1;
      d.rs2_used = 1'b1;
      d.rs1 = w.r_form.rs1;
      d.rs2 = w.r_form.rs2;
   end
   else if (op == isa_pkg::OP_IMM)
   begin
      d.rs1_used = 1'b1;
      d.rs1 = w.i_form.rs1;
   end
   // Only the two ALU classes write, and never r0
   if (op == isa_pkg::OP_REG || op == isa_pkg::OP_IMM)
   begin
      d.rd = w.r_form.rd;
      d.rd_we = (d.rd != '0);
   end
   return d;
endfunction

// Lowest free index, p0 when nothing is free
function automatic logic [`RN_PRF_AW-1:0] first_free(input logic [M_PRF-1:0] vec);
   logic [`RN_PRF_AW-1:0] idx;
   logic found;
   idx = '0;
   found = 1'b0;
   for (int k = 1; k < M_PRF; k++)
      if (vec[k] && !found)
      begin
         idx = `RN_PRF_AW'(k);
         found = 1'b1;
      end
   return idx;
endfunction

// Lane 1 always claims the second free register
function automatic logic model_stall(input isa_pkg::insn_u [`RN_ISSUE_W-1:0] w);
   rn_pkg::dec_t d0;
   rn_pkg::dec_t d1;
   int n_free;
   d0 = lane_use(w[0]);
   d1 = lane_use(w[1]);
   n_free = $countones(m_fl);
   return (d0.rd_we && n_free < 1) || (d1.rd_we && n_free < 2);
endfunction

// Source lookup with bypass from the older lane
function automatic logic [`RN_PRF_AW-1:0] map_src(input logic used,
      input logic [`RN_ARF_AW-1:0] rs, input rn_pkg::dec_t older,
      input logic [`RN_PRF_AW-1:0] older_prd);
   if (!used)
      return '0;
   if (older.rd_we && older.rd == rs)
      return older_prd;
   return m_rat[rs];
endfunction

// Expected bundle, then speculative update
function automatic bundle_t rename_bundle(input isa_pkg::insn_u [`RN_ISSUE_W-1:0] w);
   bundle_t b;
   rn_pkg::dec_t d0;
   rn_pkg::dec_t d1;
   logic [`RN_PRF_AW-1:0] pick0;
   logic [`RN_PRF_AW-1:0] pick1;
   logic [M_PRF-1:0] rest;
   d0 = lane_use(w[0]);
   d1 = lane_use(w[1]);
   pick0 = first_free(m_fl);
   // Lane 0's pick is gone for lane 1 either way
   rest = m_fl;
   rest[pick0] = 1'b0;
   pick1 = first_free(rest);
   b = '0;
   b[0].valid = 1'b1;
   b[0].insn = w[0];
   b[0].prs1 = map_src(d0.rs1_used, d0.rs1, '0, '0);
   b[0].prs2 = map_src(d0.rs2_used, d0.rs2, '0, '0);
   b[0].prd = d0.rd_we ? pick0 : '0;
   b[0].pfree = d0.rd_we ? m_rat[d0.rd] : '0;
   b[0].rd = d0.rd;
   b[0].rd_we = d0.rd_we;
   b[1].valid = 1'b1;
   b[1].insn = w[1];
   b[1].prs1 = map_src(d1.rs1_used, d1.rs1, d0, pick0);
   b[1].prs2 = map_src(d1.rs2_used, d1.rs2, d0, pick0);
   b[1].prd = d1.rd_we ? pick1 : '0;
   b[1].pfree = !d1.rd_we ? '0 : (d0.rd_we && d0.rd == d1.rd) ? pick0 : m_rat[d1.rd];
   b[1].rd = d1.rd;
   b[1].rd_we = d1.rd_we;
   // Lane order, so lane 1 wins on equal rd
   if (d0.rd_we)
   begin
      m_rat[d0.rd] = pick0;
      m_fl[pick0] = 1'b0;
   end
   if (d1.rd_we)
   begin
      m_rat[d1.rd] = pick1;
      m_fl[pick1] = 1'b0;
   end
   return b;
endfunction

// Retire moves ownership from pfree to prd
function automatic void model_commit(input rn_pkg::cmt_t c);
   if (c.valid && c.rd_we)
   begin
      m_arat[c.rd] = c.prd;
      m_afl[c.prd] = 1'b0;
      m_afl[c.pfree] = 1'b1;
      m_fl[c.pfree] = 1'b1;
   end
endfunction

function automatic void model_rollback();
   m_rat = m_arat;
   m_fl = m_afl;
endfunction

`endif

// ==== testbench/tb_rn_top.sv ====
`timescale 1ns/1ps

`include "rn_config.svh"

module tb_rn_top;

   localparam int N_BUNDLES = 300;
   localparam int MAX_CYCLES = 40 * N_BUNDLES + 200;
   // Source and sink behavior per phase
   localparam int MODE_PLAIN = 0;
   localparam int MODE_CREDIT = 1;
   localparam int MODE_STARVE = 2;
   localparam int MODE_ROLLBACK = 3;
   localparam int MODE_DRAIN = 4;

   logic clk;
   logic rst_n;
   logic in_valid;
   isa_pkg::insn_u [`RN_ISSUE_W-1:0] in_insn;
   logic in_ready;
   logic out_valid;
   rn_pkg::uop_t [`RN_ISSUE_W-1:0] out_uop;
   logic credit_ret;
   rn_pkg::cmt_t cmt;
   logic rollback;

`include "tb_rn_model.svh"

   integer seed;
   int cycles;
   // Free dispatch queue slots as the testbench sees them
   int credits;
   int n_acc;
   int phase_cyc;
   int fl_stall_cycles;
   int stall_base;
   int credit_block_cycles;
   int n_rollback;
   logic last_fire;
   bundle_t exp_q [$];
   // Writing lanes waiting to retire, oldest first
   rn_pkg::cmt_t cq [$];

   rn_top dut_i (.clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_insn(in_insn),
                 .in_ready(in_ready), .out_valid(out_valid), .out_uop(out_uop),
                 .credit_ret(credit_ret), .cmt(cmt), .rollback(rollback));

   always
   begin
      #2;
      clk = ~clk;
   end

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("*** FAILED ***");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check_value(input string name, input logic [63:0] exp,
                              input logic [63:0] got);
      if (exp !== got)
         fail_run($sformatf("mismatch %s exp %h got %h", name, exp, got));
   endtask

   // Random word, register fields often squeezed into r0..r7 for aliasing
   task automatic rand_insn(output isa_pkg::insn_u w);
      logic [31:0] r;
      logic [31:0] s;
      r = $random(seed);
      s = $random(seed);
      w = r;
      if (s[3:0] < 4'd6)
         w.r_form.opcode = isa_pkg::OP_REG;
      else if (s[3:0] < 4'd11)
         w.r_form.opcode = isa_pkg::OP_IMM;
      else if (s[3:0] < 4'd13)
         w.r_form.opcode = isa_pkg::OP_STORE;
      else if (s[3:0] < 4'd15)
         w.r_form.opcode = isa_pkg::OP_BRANCH;
      else
         w.r_form.opcode = 7'b0001111;
      if (s[4])
      begin
         w.r_form.rd = {2'b00, s[7:5]};
         w.r_form.rs1 = {2'b00, s[10:8]};
         w.r_form.rs2 = {2'b00, s[13:11]};
      end
   endtask

   // One cycle of stimulus, driven 1 ns after the edge
   task automatic drive_cycle(input int mode);
      logic [31:0] r;
      logic rb;
      logic hold;
      isa_pkg::insn_u w0;
      isa_pkg::insn_u w1;
      @(posedge clk);
      #1;
      phase_cyc++;
      r = $random(seed);
      rb = (mode == MODE_ROLLBACK) && (phase_cyc % 29 == 28);
      rollback = rb;
      // Long credit droughts in the credit phase
      hold = (mode == MODE_CREDIT) && ((phase_cyc / 24) % 2 == 0);
      credit_ret = !rb && !hold && credits < `RN_CREDITS && r[7:0] < 8'd160;
      // Starve phase keeps commits back until the free list has run dry
      hold = (mode == MODE_STARVE) && (fl_stall_cycles - stall_base < 12);
      cmt = '0;
      if (!rb && !hold && cq.size() != 0 && r[15:8] < 8'd170)
         cmt = cq.pop_front();
      if (mode == MODE_DRAIN)
         in_valid = 1'b0;
      else if (!in_valid || last_fire)
      begin
         in_valid = r[23:16] < 8'd220;
         rand_insn(w0);
         rand_insn(w1);
         in_insn[0] = w0;
         in_insn[1] = w1;
      end
   endtask

   task automatic run_phase(input int upto, input int mode);
      phase_cyc = 0;
      while (n_acc < upto)
         drive_cycle(mode);
   endtask

   // Compare at the falling edge, then apply the coming edge to the model
   task automatic check_cycle();
      logic exp_ready;
      logic stall;
      logic fire_now;
      bundle_t exp_b;
      cycles++;
      if (cycles > MAX_CYCLES)
         fail_run("timeout, the stage stopped accepting bundles");
      // Output exactly one cycle after each acceptance
      check_value("out_valid", 64'(last_fire), 64'(out_valid));
      if (out_valid)
      begin
         exp_b = exp_q.pop_front();
         for (int k = 0; k < `RN_ISSUE_W; k++)
            check_value($sformatf("out_uop[%0d]", k), 64'(exp_b[k]), 64'(out_uop[k]));
      end
      stall = in_valid && model_stall(in_insn);
      exp_ready = (credits > 0) && !rollback && !stall;
      check_value("in_ready", 64'(exp_ready), 64'(in_ready));
      if (in_valid && credits == 0)
         credit_block_cycles++;
      if (stall && credits > 0 && !rollback)
         fl_stall_cycles++;
      fire_now = in_valid && in_ready;
      if (fire_now)
      begin
         exp_b = rename_bundle(in_insn);
         exp_q.push_back(exp_b);
         for (int k = 0; k < `RN_ISSUE_W; k++)
            if (exp_b[k].rd_we)
               cq.push_back({1'b1, 1'b1, exp_b[k].rd, exp_b[k].prd, exp_b[k].pfree});
         credits--;
         n_acc++;
      end
      last_fire = fire_now;
      if (credit_ret && !rollback)
         credits++;
      model_commit(cmt);
      // Rollback squashes everything not yet retired
      if (rollback)
      begin
         model_rollback();
         credits = `RN_CREDITS;
         cq.delete();
         n_rollback++;
      end
   endtask

   always @(negedge clk)
   begin
      if (rst_n)
         check_cycle();
   end

   initial
   begin
      seed = 32'hc370_87cc;
      clk = 1'b0;
      rst_n = 1'b0;
      in_valid = 1'b0;
      in_insn = '0;
      credit_ret = 1'b0;
      cmt = '0;
      rollback = 1'b0;
      cycles = 0;
      credits = `RN_CREDITS;
      n_acc = 0;
      fl_stall_cycles = 0;
      stall_base = 0;
      credit_block_cycles = 0;
      n_rollback = 0;
      last_fire = 1'b0;
      model_reset();
      repeat (4) @(posedge clk);
      #1;
      rst_n = 1'b1;
      run_phase(100, MODE_PLAIN);
      run_phase(150, MODE_CREDIT);
      stall_base = fl_stall_cycles;
      run_phase(220, MODE_STARVE);
      run_phase(N_BUNDLES, MODE_ROLLBACK);
      // Let the last bundle come out
      while (exp_q.size() != 0)
         drive_cycle(MODE_DRAIN);
      repeat (3) drive_cycle(MODE_DRAIN);
      if (fl_stall_cycles - stall_base < 12 || credit_block_cycles == 0 || n_rollback == 0)
         fail_run("free list stall, credit stall or rollback was never exercised");
      else
      begin
         $display("*** PASSED ***");
         $finish;
      end
   end

endmodule

// ==== list.f ====
+incdir+logic
+incdir+testbench
logic/isa_pkg.sv
logic/rn_pkg.sv
logic/rn_decode.sv
logic/rn_rat.sv
logic/rn_fl.sv
logic/rn_dispatch.sv
logic/rn_top.sv
testbench/tb_rn_top.sv

// ==== run.sh ====
#!/bin/sh
# Compile the rename stage with its testbench and run it
# The run counts as good only if the simulation prints the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_rn_top -Mdir obj_dir \
   && ./obj_dir/Vtb_rn_top | tee /dev/stderr | grep -qF '*** PASSED ***' \
   && echo "simulation run ok" \
   || { echo "simulation run not ok"; exit 1; }
